/* Makefile */
# Verilator build and run of the miss issue stage testbench

TOP := devtlb_miss_issue_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

obj_dir/V$(TOP): sim.f $(wildcard common/* source/*.sv dv/*)
	verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

# Passes only when the pass line shows up in the run output
test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* common/devtlb_macros.svh */
//--------------------------------------------------------------------
// Sizing defines for the device TLB miss issue stage
// Port count, miss queue depth and page walker slot count
//--------------------------------------------------------------------

`ifndef DEVTLB_MACROS_SVH
`define DEVTLB_MACROS_SVH

// Lookup ports feeding the miss queues
`define DEVTLB_NUM_PORTS 4

// Entries in each per-port miss queue
`define DEVTLB_FIFO_DEPTH 4

// Concurrent walks the page walker can hold
`define DEVTLB_WALK_CREDITS 3

// Width of a port index, never below one bit
`define DEVTLB_PORT_ID_W ((`DEVTLB_NUM_PORTS > 1) ? $clog2(`DEVTLB_NUM_PORTS) : 1)

`endif

/* common/devtlb_pkg.sv */
//--------------------------------------------------------------------
// Shared types for the device TLB miss issue stage
//--------------------------------------------------------------------

`include "devtlb_macros.svh"

package devtlb_pkg;

    //------------------------------------------------------------------
    // Miss request from one lookup port
    //------------------------------------------------------------------
    typedef struct packed {
        logic [19:0] vpn;   // Virtual page number
        logic [7:0]  asid;  // Address space id
        logic [3:0]  tag;   // Requester tag
    } miss_req_t;           // 32 bits in all

    // Index of a lookup port
    typedef logic [`DEVTLB_PORT_ID_W-1:0] port_id_t;

    //------------------------------------------------------------------
    // Walk request handed to the page walker
    //------------------------------------------------------------------
    typedef struct packed {
        port_id_t  port;    // Source lookup port
        miss_req_t req;     // Miss as pushed by that port
    } walk_req_t;

endpackage

/* dv/devtlb_miss_issue_tb.sv */
//----------------------------------------------------------------------
// Testbench for the miss issue top with file-driven stimulus and checks
// Clock, reset, per-cycle drive, output compare and final report
//----------------------------------------------------------------------

`include "devtlb_macros.svh"

module devtlb_miss_issue_tb
    import devtlb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NP         = `DEVTLB_NUM_PORTS;
    localparam int    NUM_TESTS  = 6;
    localparam int    MAX_LINES  = 256;     // Read loop bound
    localparam int    MAX_CYCLES = 2000;    // Whole-run bound
    localparam string STIM_FILE  = "dv/devtlb_stim.txt";

    // Outputs expected after one stimulus cycle
    typedef struct packed {
        logic          walk;
        port_id_t      port;
        miss_req_t     req;
        logic [NP-1:0] full;
    } expect_t;

    // One clock cycle of stimulus plus its expectation
    typedef struct packed {
        logic [7:0]         test;
        logic [NP-1:0]      push;
        miss_req_t [NP-1:0] pay;
        logic               done;
        expect_t            exp;
    } cycle_t;

    logic          clk;
    logic          rst_b;
    logic [NP-1:0] miss_push;
    miss_req_t     miss_req [NP];
    logic [NP-1:0] miss_full;
    logic          walk_done;
    logic          walk_valid;
    walk_req_t     walk_req;

    cycle_t cycles [$];     // Whole run loaded up front
    int     errors;
    int     checks;
    int     tests_run;
    int     test_errs;      // Mismatches in the running test

    devtlb_miss_issue_top devtlb_miss_issue_top_i (
        .clk        (clk),
        .rst_b      (rst_b),
        .miss_push  (miss_push),
        .miss_req   (miss_req),
        .miss_full  (miss_full),
        .walk_done  (walk_done),
        .walk_valid (walk_valid),
        .walk_req   (walk_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------
    function automatic string test_name(input int test);
        case (test)
            1:       return "reset state";
            2:       return "single-port issue";
            3:       return "round-robin rotation";
            4:       return "priority after a gap";
            5:       return "credit back-pressure";
            6:       return "queue full";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input int test, input string field,
                                   input logic [31:0] got, input logic [31:0] want);
        errors++;
        test_errs++;
        $display("mismatch at %0d ns: test %0d %s got %0h expected %0h",
                 $time, test, field, got, want);
    endtask

    task automatic check_outputs(input int test, input expect_t e);
        checks++;
        if (walk_valid !== e.walk) begin
            report_mismatch(test, "walk_valid", 32'(walk_valid), 32'(e.walk));
        end
        if (e.walk && walk_valid) begin     // Payload only meaningful with valid
            if (walk_req.port !== e.port) begin
                report_mismatch(test, "walk_req.port", 32'(walk_req.port), 32'(e.port));
            end
            if (walk_req.req !== e.req) begin
                report_mismatch(test, "walk_req.req", 32'(walk_req.req), 32'(e.req));
            end
        end
        if (miss_full !== e.full) begin
            report_mismatch(test, "miss_full", 32'(miss_full), 32'(e.full));
        end
    endtask

    task automatic finish_test(input int test);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: passed", test, test_name(test));
        end else begin
            $display("test %0d %s: %0d mismatches", test, test_name(test), test_errs);
        end
        test_errs = 0;
    endtask

    //------------------------------------------------------------------
    // Stimulus file into the cycle queue
    //------------------------------------------------------------------
    task automatic load_stimulus();
        int            fd;
        int            nlines;
        int            nf;
        int            delay;
        int            test;
        string         text;
        logic [NP-1:0] push;
        logic [31:0]   p0, p1, p2, p3;
        logic          done;
        logic          ev;
        logic [31:0]   eport;
        logic [31:0]   epay;
        logic [NP-1:0] efull;
        logic [NP-1:0] last_full;
        cycle_t        c;
        cycle_t        idle;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        nlines    = 0;
        last_full = '0;
        while (!$feof(fd) && nlines < MAX_LINES) begin
            nlines++;
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 8 || text.getc(0) == "#") begin
                continue;       // Blank or column notes
            end
            nf = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h", test, push,
                         p0, p1, p2, p3, done, ev, eport, epay, efull);
            if (nf != 11) begin
                $display("stimulus line %0d is malformed, %0d fields read", nlines, nf);
                errors++;
                continue;
            end
            c          = '0;
            c.test     = 8'(test);
            c.push     = push;
            c.pay[0]   = miss_req_t'(p0);
            c.pay[1]   = miss_req_t'(p1);
            c.pay[2]   = miss_req_t'(p2);
            c.pay[3]   = miss_req_t'(p3);
            c.done     = done;
            c.exp.walk = ev;
            c.exp.port = port_id_t'(eport);
            c.exp.req  = miss_req_t'(epay);
            c.exp.full = efull;
            // Idle cycles before a credit return in test 6 leave the DUT still
            if (test == 6 && done) begin
                delay         = $urandom % 4;
                idle          = '0;
                idle.test     = c.test;
                idle.exp.full = last_full;
                for (int k = 0; k < delay; k++) begin
                    cycles.push_back(idle);
                end
            end
            cycles.push_back(c);
            last_full = efull;
        end
        if (!$feof(fd)) begin
            $display("stimulus file is longer than %0d lines", MAX_LINES);
            errors++;
        end
        $fclose(fd);
    endtask

    //------------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------------
    initial begin : main
        cycle_t  c;
        expect_t pend;          // Expectation of the previous cycle
        int      pend_test;
        logic    have_pend;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        test_errs = 0;
        rst_b     <= 1'b0;
        miss_push <= '0;
        walk_done <= 1'b0;
        for (int p = 0; p < NP; p++) begin
            miss_req[p] <= '0;
        end
        void'($urandom(48));
        if (`DEVTLB_WALK_CREDITS != 3 || `DEVTLB_FIFO_DEPTH != 4 || NP != 4) begin
            $display("stimulus file is written for 4 ports, depth 4 and 3 credits");
            errors++;
        end
        load_stimulus();

        repeat (2) @(posedge clk);  // Two reset cycles
        rst_b <= 1'b1;

        // Outputs still hold their reset values here
        @(negedge clk);
        checks++;
        if (walk_valid !== 1'b0) begin
            report_mismatch(1, "walk_valid after reset", 32'(walk_valid), 32'h0);
        end
        if (miss_full !== '0) begin
            report_mismatch(1, "miss_full after reset", 32'(miss_full), 32'h0);
        end

        have_pend = 1'b0;
        pend_test = 0;
        pend      = '0;
        foreach (cycles[i]) begin
            c = cycles[i];
            @(posedge clk);
            miss_push <= c.push;
            for (int p = 0; p < NP; p++) begin
                miss_req[p] <= c.pay[p];
            end
            walk_done <= c.done;
            @(negedge clk);         // Outputs settled from last edge
            if (have_pend) begin
                check_outputs(pend_test, pend);
                if (pend_test != int'(c.test)) begin
                    finish_test(pend_test);
                end
            end
            pend      = c.exp;
            pend_test = int'(c.test);
            have_pend = 1'b1;
        end

        // Trailing idle cycle for the last line
        @(posedge clk);
        miss_push <= '0;
        walk_done <= 1'b0;
        @(negedge clk);
        if (have_pend) begin
            check_outputs(pend_test, pend);
            finish_test(pend_test);
        end

        $display("summary: %0d of %0d tests run, %0d checks, %0d mismatches or errors",
                 tests_run, NUM_TESTS, checks, errors);
        if (errors == 0 && tests_run == NUM_TESTS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Run length guard
    initial begin : watchdog
        int n;
        n = 0;
        while (n < MAX_CYCLES) begin
            @(posedge clk);
            n++;
        end
        $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

/* dv/devtlb_stim.txt */
# One clock cycle per line, hex fields: test push p0 p1 p2 p3 done exp_walk exp_port exp_payload exp_full
# push and exp_full carry one bit per port, expectations are the outputs after this cycle's edge
# 1 reset state
1 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
1 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
# 2 single-port issue
2 4 00000000 00000000 12345A73 00000000 0 0 0 00000000 0
2 0 00000000 00000000 00000000 00000000 0 1 2 12345A73 0
2 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
2 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
# 3 round-robin rotation
3 1 3000A010 00000000 00000000 00000000 0 0 0 00000000 0
3 f 3000B011 3001A110 3002A210 3003A310 0 1 0 3000A010 0
3 e 00000000 3001B111 3002B211 3003B311 0 1 1 3001A110 0
3 0 00000000 00000000 00000000 00000000 1 1 2 3002A210 0
3 0 00000000 00000000 00000000 00000000 1 1 3 3003A310 0
3 0 00000000 00000000 00000000 00000000 1 1 0 3000B011 0
3 0 00000000 00000000 00000000 00000000 1 1 1 3001B111 0
3 0 00000000 00000000 00000000 00000000 1 1 2 3002B211 0
3 0 00000000 00000000 00000000 00000000 1 1 3 3003B311 0
3 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
3 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
# 4 priority after a gap
4 2 00000000 4001C120 00000000 00000000 0 0 0 00000000 0
4 0 00000000 00000000 00000000 00000000 0 1 1 4001C120 0
4 9 4000C020 00000000 00000000 4003C320 0 0 0 00000000 0
4 0 00000000 00000000 00000000 00000000 1 1 3 4003C320 0
4 0 00000000 00000000 00000000 00000000 0 1 0 4000C020 0
4 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
4 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
# 5 credit back-pressure
5 6 00000000 5001D130 5002D230 00000000 0 0 0 00000000 0
5 6 00000000 5001E131 5002E231 00000000 0 1 1 5001D130 0
5 0 00000000 00000000 00000000 00000000 0 1 2 5002D230 0
5 0 00000000 00000000 00000000 00000000 0 1 1 5001E131 0
5 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
5 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
5 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
5 0 00000000 00000000 00000000 00000000 0 1 2 5002E231 0
5 0 00000000 00000000 00000000 00000000 0 0 0 00000000 0
# 6 queue full
6 1 6000F041 00000000 00000000 00000000 0 0 0 00000000 0
6 1 6000F042 00000000 00000000 00000000 0 0 0 00000000 0
6 1 6000F043 00000000 00000000 00000000 0 0 0 00000000 0
6 1 6000F044 00000000 00000000 00000000 0 0 0 00000000 1
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 1
6 0 00000000 00000000 00000000 00000000 0 1 0 6000F041 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
6 0 00000000 00000000 00000000 00000000 0 1 0 6000F042 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
6 0 00000000 00000000 00000000 00000000 0 1 0 6000F043 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
6 0 00000000 00000000 00000000 00000000 0 1 0 6000F044 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0
6 0 00000000 00000000 00000000 00000000 1 0 0 00000000 0

/* sim.f */
+incdir+common
common/devtlb_pkg.sv
source/devtlb_miss_fifo.sv
source/devtlb_rrarb.sv
source/devtlb_walk_issue.sv
source/devtlb_miss_issue_top.sv
dv/devtlb_miss_issue_tb.sv

/* source/devtlb_miss_fifo.sv */
//--------------------------------------------------------------------
// Per-port miss queue as a circular buffer with push and pop strobes
//--------------------------------------------------------------------

module devtlb_miss_fifo
    import devtlb_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_b,

    input  logic      push,       // One-cycle strobe from lookup port
    input  miss_req_t push_data,
    input  logic      pop,        // Grant bit from arbiter
    output miss_req_t head,       // Oldest entry
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    miss_req_t          mem [DEPTH];    // Payload storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;          // Occupancy
    logic               push_ok;

    // Push while full is dropped
    assign push_ok = push && !full;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];     // Head visible while not empty

    //------------------------------------------------------------------
    // Storage write
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    //------------------------------------------------------------------
    // Pointers and occupancy
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                // Wrap without relying on power-of-two depth
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;   // Fill
                2'b01:   count <= count - 1'b1;   // Drain
                default: count <= count;          // Idle or both at once
            endcase
        end
    end

endmodule

/* source/devtlb_miss_issue_top.sv */
//--------------------------------------------------------------------
// Miss issue stage top, per-port queues, arbiter and walk issue
//--------------------------------------------------------------------

`include "devtlb_macros.svh"

module devtlb_miss_issue_top
    import devtlb_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_b,

    // Lookup port side
    input  logic [`DEVTLB_NUM_PORTS-1:0] miss_push,
    input  miss_req_t                    miss_req [`DEVTLB_NUM_PORTS],
    output logic [`DEVTLB_NUM_PORTS-1:0] miss_full,

    // Page walker side
    input  logic                         walk_done,
    output logic                         walk_valid,
    output walk_req_t                    walk_req
);

    //------------------------------------------------------------------
    // Internal wires
    //------------------------------------------------------------------
    logic [`DEVTLB_NUM_PORTS-1:0] fifo_empty;
    logic [`DEVTLB_NUM_PORTS-1:0] arb_req;     // Ports with a queued miss
    logic [`DEVTLB_NUM_PORTS-1:0] gnt;         // Pop strobes, one-hot
    miss_req_t                    heads [`DEVTLB_NUM_PORTS];
    logic                         credit_avail;

    // Any non-empty queue requests
    assign arb_req = ~fifo_empty;

    //------------------------------------------------------------------
    // Per-port miss queues
    //------------------------------------------------------------------
    for (genvar p = 0; p < `DEVTLB_NUM_PORTS; p++) begin : g_fifo
        devtlb_miss_fifo #(
            .DEPTH     (`DEVTLB_FIFO_DEPTH)
        ) devtlb_miss_fifo_i (
            .clk       (clk),
            .rst_b     (rst_b),
            .push      (miss_push[p]),
            .push_data (miss_req[p]),
            .pop       (gnt[p]),            // Granted head leaves
            .head      (heads[p]),
            .empty     (fifo_empty[p]),
            .full      (miss_full[p])
        );
    end

    //------------------------------------------------------------------
    // Port arbiter, gated by free walk slots
    //------------------------------------------------------------------
    devtlb_rrarb #(
        .REQ_W   (`DEVTLB_NUM_PORTS)
    ) devtlb_rrarb_i (
        .clk     (clk),
        .rst_b   (rst_b),
        .arb_rs  (credit_avail),
        .arb_req (arb_req),
        .arb_gnt (gnt)
    );

    //------------------------------------------------------------------
    // Walk request register and credits
    //------------------------------------------------------------------
    devtlb_walk_issue devtlb_walk_issue_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .gnt          (gnt),
        .heads        (heads),
        .walk_done    (walk_done),
        .credit_avail (credit_avail),
        .walk_valid   (walk_valid),
        .walk_req     (walk_req)
    );

endmodule

/* source/devtlb_rrarb.sv */
//--------------------------------------------------------------------
// Round-robin arbiter with resource-available input
// Priority mask only moves when a grant is given
//--------------------------------------------------------------------

module devtlb_rrarb #(
    parameter int REQ_W = 4
) (
    input  logic             clk,
    input  logic             rst_b,

    input  logic             arb_rs,     // Resource free
    input  logic [REQ_W-1:0] arb_req,
    output logic [REQ_W-1:0] arb_gnt     // One-hot, same cycle as request
);

    localparam int IDW = (REQ_W > 1) ? $clog2(REQ_W) : 1;

    logic [REQ_W-1:0] mask;         // Set bits are low priority
    logic [REQ_W-1:0] nxt_mask;
    logic [REQ_W-1:0] hp_req;       // Above last winner
    logic [REQ_W-1:0] lp_req;       // Last winner and below
    logic [IDW-1:0]   hp_idx;
    logic [IDW-1:0]   lp_idx;
    logic [IDW-1:0]   win_idx;

    //------------------------------------------------------------------
    // Winner select
    //------------------------------------------------------------------
    always_comb begin
        hp_req = arb_req & ~mask;
        lp_req = arb_req & mask;
        hp_idx = '0;
        lp_idx = '0;

        // Walk down so the lowest set bit wins
        for (int i = REQ_W - 1; i >= 0; i--) begin
            if (hp_req[i]) begin
                hp_idx = IDW'(i);
            end
            if (lp_req[i]) begin
                lp_idx = IDW'(i);
            end
        end

        // High half first, else fall back to low half
        win_idx = (|hp_req) ? hp_idx : lp_idx;

        // Winner and everything below drop to low priority
        for (int i = 0; i < REQ_W; i++) begin
            nxt_mask[i] = (IDW'(i) <= win_idx);
        end

        // No grant without a request or without the resource
        for (int i = 0; i < REQ_W; i++) begin
            arb_gnt[i] = arb_rs && (|arb_req) && (win_idx == IDW'(i));
        end
    end

    //------------------------------------------------------------------
    // Priority mask
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            mask <= '0;                 // All ports high priority
        end else if (|arb_gnt) begin
            mask <= nxt_mask;           // Holds while resource busy
        end
    end

endmodule

/* source/devtlb_walk_issue.sv */
//--------------------------------------------------------------------
// Walk credit counter and registered walk request output
//--------------------------------------------------------------------

`include "devtlb_macros.svh"

module devtlb_walk_issue
    import devtlb_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_b,

    input  logic [`DEVTLB_NUM_PORTS-1:0] gnt,            // One-hot from arbiter
    input  miss_req_t                    heads [`DEVTLB_NUM_PORTS],
    input  logic                         walk_done,      // Returns one credit
    output logic                         credit_avail,
    output logic                         walk_valid,
    output walk_req_t                    walk_req
);

    localparam int CRD_W = $clog2(`DEVTLB_WALK_CREDITS + 1);

    logic [CRD_W-1:0] credits;      // Free walk slots
    logic             issue;
    port_id_t         gnt_id;

    assign issue        = |gnt;
    assign credit_avail = (credits != '0);

    // One-hot to index, OR of set positions
    always_comb begin
        gnt_id = '0;
        for (int i = 0; i < `DEVTLB_NUM_PORTS; i++) begin
            if (gnt[i]) begin
                gnt_id = gnt_id | port_id_t'(i);
            end
        end
    end

    // Control state and credit count
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            walk_valid <= 1'b0;
            credits    <= CRD_W'(`DEVTLB_WALK_CREDITS);
        end else begin
            walk_valid <= issue;        // One cycle after grant
            case ({issue, walk_done})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;     // Both cancel out
            endcase
        end
    end

    // Payload register, loaded with the granted head
    always_ff @(posedge clk) begin
        if (issue) begin
            walk_req <= '{port: gnt_id, req: heads[gnt_id]};
        end
    end

endmodule
